//--- verilog/dsp_config.svh
// Readout DSP configuration
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// one sample lane
`define LANE_W 16
// lanes per ADC word
`define ADC_LANES 4
// lanes per DAC word
`define DAC_LANES 16
// DAC lane step for undersampling
`define UNDERSAMPLE 4
// number of DAC words
`define N_DAC 4
// accumulator and result width
`define ACC_W 32
// result shift amount width
`define SHIFT_W 5
// accumulation buffer address width
`define ACCBUF_ADDR_W 6
// shot counter width
`define SHOT_W 32

`endif

//--- verilog/dsp_pkg.sv
// Readout DSP shared types
`include "dsp_config.svh"

package dsp_pkg;

	// shot sequencer states, gray-like codes
	typedef enum logic [3:0] {
		idle      = 4'b0000,
		start     = 4'b0001,
		proc_run  = 4'b0011,
		elem_busy = 4'b0010,
		more_shot = 4'b0110,
		shot_add  = 4'b0111,
		done      = 4'b0101
	} seq_state_e;

	// baseband source select
	// code 3 keeps the previous choice
	typedef enum logic [1:0] {
		bb_adc   = 2'd0,
		bb_dac_a = 2'd1,
		bb_dac_b = 2'd2,
		bb_hold  = 2'd3
	} bb_sel_e;

	// one accumulator result
	typedef struct packed {
		logic                     valid;
		logic signed [`ACC_W-1:0] value;
	} acc_result_t;

	// one accumulation buffer write port
	typedef struct packed {
		logic                      we;
		logic [`ACCBUF_ADDR_W-1:0] addr;
		logic [`ACC_W-1:0]         data;
	} accbuf_wr_t;

	// measurement bits, one per channel
	// bits carries the result sign
	typedef struct packed {
		logic [1:0] valid;
		logic [1:0] bits;
	} meas_bits_t;

endpackage

//--- verilog/shot_sequencer.sv
// Multi-shot sequencer
`include "dsp_config.svh"

module shot_sequencer (
	input  logic               dspif,
	input  logic               rst_n,
	input  logic               stb_start,
	input  logic [`SHOT_W-1:0] nshot,
	// status from the four processor cores
	input  logic [3:0]         proc_done,
	input  logic [3:0]         no_busy,
	output logic               proc_reset,
	output logic               proc_start,
	output logic [`SHOT_W-1:0] shot_cnt,
	output logic               last_shot_done,
	output logic               procdone_flag
);

	dsp_pkg::seq_state_e state;
	dsp_pkg::seq_state_e next_state;

	// latched shot target, 0 means endless
	logic [`SHOT_W-1:0] nshot_r;
	// running index of the current shot
	logic [`SHOT_W-1:0] shot_idx;
	logic [`SHOT_W-1:0] shot_idx_next;
	logic               more_shots;
	// all-core status, registered
	logic               all_done_r;
	logic               all_idle_r;

	// next state
	always_comb begin
		next_state = dsp_pkg::idle;
		case (state)
			dsp_pkg::idle:      next_state = stb_start ? dsp_pkg::start : dsp_pkg::idle;
			dsp_pkg::start:     next_state = dsp_pkg::proc_run;
			dsp_pkg::proc_run:  next_state = all_done_r ? dsp_pkg::elem_busy : dsp_pkg::proc_run;
			dsp_pkg::elem_busy: next_state = all_idle_r ? dsp_pkg::more_shot : dsp_pkg::elem_busy;
			dsp_pkg::more_shot: next_state = more_shots ? dsp_pkg::shot_add : dsp_pkg::done;
			dsp_pkg::shot_add:  next_state = dsp_pkg::start;
			dsp_pkg::done:      next_state = dsp_pkg::idle;
			default:            next_state = dsp_pkg::idle;
		endcase
	end

	// state and outputs, all registered from next_state
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state          <= dsp_pkg::idle;
			nshot_r        <= '0;
			shot_idx       <= '0;
			shot_cnt       <= '0;
			proc_reset     <= 1'b1;
			proc_start     <= 1'b0;
			last_shot_done <= 1'b0;
		end else begin
			state          <= next_state;
			// one-cycle start strobe to the cores
			proc_start     <= (next_state == dsp_pkg::start);
			// cores run only in start and proc_run
			proc_reset     <= !((next_state == dsp_pkg::start) ||
				(next_state == dsp_pkg::proc_run));
			last_shot_done <= (next_state == dsp_pkg::done);
			case (next_state)
				dsp_pkg::idle: begin
					shot_idx <= '0;
					// target only taken while idle
					nshot_r  <= nshot;
				end
				dsp_pkg::shot_add: begin
					shot_idx <= shot_idx_next;
					// export index of the shot just finished
					shot_cnt <= shot_idx;
				end
				dsp_pkg::done: begin
					shot_idx <= '0;
				end
				default: begin
				end
			endcase
		end
	end

	// pipelined next-count compare
	// settles long before more_shot is reached
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			shot_idx_next <= '0;
			more_shots    <= 1'b0;
			all_done_r    <= 1'b0;
			all_idle_r    <= 1'b0;
		end else begin
			shot_idx_next <= shot_idx + 1'b1;
			more_shots    <= (shot_idx_next != nshot_r) || (nshot_r == '0);
			all_done_r    <= &proc_done;
			all_idle_r    <= &no_busy;
		end
	end

	// sticky done, cleared by the next start
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			procdone_flag <= 1'b0;
		end else if (all_done_r) begin
			procdone_flag <= 1'b1;
		end else if (proc_start) begin
			procdone_flag <= 1'b0;
		end
	end

endmodule

//--- verilog/baseband_select.sv
// Baseband source selection
`include "dsp_config.svh"

module baseband_select (
	input  logic                                     dspif,
	input  logic                                     rst_n,
	input  logic [`ADC_LANES*`LANE_W-1:0]            adc,
	input  logic [`N_DAC-1:0][`DAC_LANES*`LANE_W-1:0] dac,
	input  dsp_pkg::bb_sel_e                         bb1_sel,
	input  dsp_pkg::bb_sel_e                         bb2_sel,
	output logic [`ADC_LANES*`LANE_W-1:0]            bb1,
	output logic [`ADC_LANES*`LANE_W-1:0]            bb2
);

	// first stage, registered inputs
	logic [`ADC_LANES*`LANE_W-1:0]             adc_r;
	logic [`N_DAC-1:0][`ADC_LANES*`LANE_W-1:0] dac_us;

	always_ff @(posedge dspif) begin
		adc_r <= adc;
		// keep every UNDERSAMPLE-th DAC lane
		for (int i = 0; i < `N_DAC; i++) begin
			for (int j = 0; j < `ADC_LANES; j++) begin
				dac_us[i][j*`LANE_W +: `LANE_W] <= dac[i][j*`UNDERSAMPLE*`LANE_W +: `LANE_W];
			end
		end
	end

	// second stage, source selectors
	// channel 1 sees dac 0/1, channel 2 sees dac 2/3
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			bb1 <= '0;
			bb2 <= '0;
		end else begin
			case (bb1_sel)
				dsp_pkg::bb_adc:   bb1 <= adc_r;
				dsp_pkg::bb_dac_a: bb1 <= dac_us[0];
				dsp_pkg::bb_dac_b: bb1 <= dac_us[1];
				default:           bb1 <= bb1;
			endcase
			case (bb2_sel)
				dsp_pkg::bb_adc:   bb2 <= adc_r;
				dsp_pkg::bb_dac_a: bb2 <= dac_us[2];
				dsp_pkg::bb_dac_b: bb2 <= dac_us[3];
				default:           bb2 <= bb2;
			endcase
		end
	end

endmodule

//--- verilog/meas_accumulator.sv
// Gated measurement accumulator
`include "dsp_config.svh"

module meas_accumulator (
	input  logic                          dspif,
	input  logic                          rst_n,
	input  logic [`ADC_LANES*`LANE_W-1:0] bb,
	input  logic                          acc_gate,
	input  logic [`SHIFT_W-1:0]           shift,
	output dsp_pkg::acc_result_t          result
);

	// sum of the signed lanes of one word
	logic signed [`ACC_W-1:0] lane_sum;
	// running integral over the gate
	logic signed [`ACC_W-1:0] acc;
	logic                     gate_d;
	logic                     res_valid;
	logic signed [`ACC_W-1:0] res_value;

	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < `ADC_LANES; i++) begin
			// sign extend each lane before adding
			lane_sum = lane_sum + `ACC_W'(signed'(bb[i*`LANE_W +: `LANE_W]));
		end
	end

	// gate tracking and integration
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			gate_d    <= 1'b0;
			acc       <= '0;
			res_valid <= 1'b0;
		end else begin
			gate_d    <= acc_gate;
			// strobe on first low cycle after the gate
			res_valid <= gate_d && !acc_gate;
			if (acc_gate) begin
				acc <= acc + lane_sum;
			end else if (gate_d) begin
				// result taken, start over
				acc <= '0;
			end
		end
	end

	// scaled result, arithmetic shift keeps the sign
	always_ff @(posedge dspif) begin
		if (gate_d && !acc_gate) begin
			res_value <= acc >>> shift;
		end
	end

	always_comb begin
		result.valid = res_valid;
		result.value = res_value;
	end

endmodule

//--- verilog/accbuf_writer.sv
// Accumulation buffer writer
`include "dsp_config.svh"

module accbuf_writer (
	input  logic                           dspif,
	input  logic                           rst_n,
	input  dsp_pkg::acc_result_t [1:0]     res,
	input  logic                           resetacc,
	output dsp_pkg::accbuf_wr_t [1:0]      accbuf,
	output dsp_pkg::meas_bits_t            meas
);

	logic                                resetacc_r;
	logic [1:0]                          we_r;
	logic [1:0][`ACCBUF_ADDR_W-1:0]      addr_r;
	logic [1:0][`ACC_W-1:0]              data_r;
	logic [1:0]                          mvalid_r;
	logic [1:0]                          mbit_r;

	// strobes and write pointers
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			resetacc_r <= 1'b0;
			we_r       <= '0;
			addr_r     <= '0;
			mvalid_r   <= '0;
		end else begin
			resetacc_r <= resetacc;
			for (int i = 0; i < 2; i++) begin
				we_r[i]     <= res[i].valid;
				// measurement bit one cycle behind the write
				mvalid_r[i] <= we_r[i];
				if (resetacc_r) begin
					addr_r[i] <= '0;
				end else if (we_r[i] && !(&addr_r[i])) begin
					// advance after each write, lock on the last slot
					addr_r[i] <= addr_r[i] + 1'b1;
				end
			end
		end
	end

	// write data and sign bits
	always_ff @(posedge dspif) begin
		for (int i = 0; i < 2; i++) begin
			data_r[i] <= res[i].value;
			// threshold at zero, msb is the sign
			mbit_r[i] <= data_r[i][`ACC_W-1];
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			accbuf[i].we   = we_r[i];
			accbuf[i].addr = addr_r[i];
			accbuf[i].data = data_r[i];
		end
		meas.valid = mvalid_r;
		meas.bits  = mbit_r;
	end

endmodule

//--- verilog/dsp_readout_top.sv
// Readout DSP top level
`include "dsp_config.svh"

module dsp_readout_top (
	input  logic                                     dspif,
	input  logic                                     rst_n,
	// shot control and core status
	input  logic                                     stb_start,
	input  logic [`SHOT_W-1:0]                       nshot,
	input  logic [3:0]                               proc_done,
	input  logic [3:0]                               no_busy,
	output logic                                     proc_reset,
	output logic                                     proc_start,
	output logic [`SHOT_W-1:0]                       shot_cnt,
	output logic                                     last_shot_done,
	output logic                                     procdone_flag,
	// sample inputs and source select
	input  logic [`ADC_LANES*`LANE_W-1:0]            adc,
	input  logic [`N_DAC-1:0][`DAC_LANES*`LANE_W-1:0] dac,
	input  dsp_pkg::bb_sel_e                         bb1_sel,
	input  dsp_pkg::bb_sel_e                         bb2_sel,
	output logic [`ADC_LANES*`LANE_W-1:0]            bb1,
	output logic [`ADC_LANES*`LANE_W-1:0]            bb2,
	// accumulation control, one gate per channel
	input  logic [1:0]                               acc_gate,
	input  logic [`SHIFT_W-1:0]                      shift,
	input  logic                                     resetacc,
	output dsp_pkg::accbuf_wr_t [1:0]                accbuf,
	output dsp_pkg::meas_bits_t                      meas
);

	dsp_pkg::acc_result_t [1:0] acc_res;

	// sequencer, independent of the sample path
	shot_sequencer u_seq (
		.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
		.proc_done(proc_done), .no_busy(no_busy), .proc_reset(proc_reset),
		.proc_start(proc_start), .shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done), .procdone_flag(procdone_flag)
	);

	baseband_select u_bbsel (
		.dspif(dspif), .rst_n(rst_n), .adc(adc), .dac(dac),
		.bb1_sel(bb1_sel), .bb2_sel(bb2_sel), .bb1(bb1), .bb2(bb2)
	);

	// channel 1 integrates bb1
	meas_accumulator u_acc1 (
		.dspif(dspif), .rst_n(rst_n), .bb(bb1), .acc_gate(acc_gate[0]),
		.shift(shift), .result(acc_res[0])
	);

	// channel 2 integrates bb2
	meas_accumulator u_acc2 (
		.dspif(dspif), .rst_n(rst_n), .bb(bb2), .acc_gate(acc_gate[1]),
		.shift(shift), .result(acc_res[1])
	);

	accbuf_writer u_wr (
		.dspif(dspif), .rst_n(rst_n), .res(acc_res), .resetacc(resetacc),
		.accbuf(accbuf), .meas(meas)
	);

endmodule

//--- testbench/tb_checker.sv
// Readout DSP response checker
`include "dsp_config.svh"

module tb_checker (
	input  logic                                     dspif,
	input  logic                                     rst_n,
	input  logic                                     stb_start,
	input  logic [`SHOT_W-1:0]                       nshot,
	input  logic                                     proc_reset,
	input  logic                                     proc_start,
	input  logic [`SHOT_W-1:0]                       shot_cnt,
	input  logic                                     last_shot_done,
	input  logic                                     procdone_flag,
	input  logic [`ADC_LANES*`LANE_W-1:0]            adc,
	input  logic [`N_DAC-1:0][`DAC_LANES*`LANE_W-1:0] dac,
	input  logic [1:0][1:0]                          sel,
	input  logic [1:0][`ADC_LANES*`LANE_W-1:0]       bb,
	input  logic [1:0]                               acc_gate,
	input  logic [`SHIFT_W-1:0]                      shift,
	input  logic                                     resetacc,
	input  dsp_pkg::accbuf_wr_t [1:0]                accbuf,
	input  dsp_pkg::meas_bits_t                      meas,
	input  logic                                     final_check,
	output int                                       errors = 0
);
	timeunit 1ns;
	timeprecision 100ps;

	int                                        cyc = 0;
	logic                                      rst_prev = 1'b0;
	logic                                      armed = 1'b0;
	logic                                      ps_prev = 1'b0;
	logic                                      in_run = 1'b0;
	logic [`SHOT_W-1:0]                        run_n;
	int                                        starts;
	int                                        start_due;
	int                                        clear_due = -1;
	logic [1:0][`ADC_LANES*`LANE_W-1:0]        exp_bb;
	logic [`ADC_LANES*`LANE_W-1:0]             adc_d;
	logic [`N_DAC-1:0][`DAC_LANES*`LANE_W-1:0] dac_d;
	logic signed [`ACC_W-1:0]                  ref_sum [2];
	logic [1:0]                                gate_prev;
	int                                        writes [2];
	// pending results, values with the cycle they are due
	logic signed [`ACC_W-1:0]                  val_q [2][$];
	int                                        due_q [2][$];
	logic                                      sign_q [2][$];
	int                                        sign_due [2][$];
	logic signed [`ACC_W-1:0]                  v;
	int                                        d;

	// lanes 0, 4, 8, 12 of a DAC word
	function automatic logic [`ADC_LANES*`LANE_W-1:0] undersample(
		input logic [`DAC_LANES*`LANE_W-1:0] w);
		logic [`ADC_LANES*`LANE_W-1:0] r;
		for (int j = 0; j < `ADC_LANES; j++) begin
			r[j*`LANE_W +: `LANE_W] = w[j*`UNDERSAMPLE*`LANE_W +: `LANE_W];
		end
		return r;
	endfunction

	function automatic logic [`ADC_LANES*`LANE_W-1:0] pick_source(input logic [1:0] s,
		input logic [`ADC_LANES*`LANE_W-1:0] a, input logic [`DAC_LANES*`LANE_W-1:0] da,
		input logic [`DAC_LANES*`LANE_W-1:0] db, input logic [`ADC_LANES*`LANE_W-1:0] held);
		case (s)
			2'd0: return a;
			2'd1: return undersample(da);
			2'd2: return undersample(db);
			default: return held;
		endcase
	endfunction

	function automatic logic signed [`ACC_W-1:0] lane_total(
		input logic [`ADC_LANES*`LANE_W-1:0] w);
		logic signed [`ACC_W-1:0] s;
		s = '0;
		for (int i = 0; i < `ADC_LANES; i++) begin
			s = s + `ACC_W'($signed(w[i*`LANE_W +: `LANE_W]));
		end
		return s;
	endfunction

	function automatic logic signed [`ACC_W-1:0] scaled(input logic signed [`ACC_W-1:0] s,
		input logic [`SHIFT_W-1:0] sh);
		return s >>> sh;
	endfunction

	function automatic logic sign_of(input logic signed [`ACC_W-1:0] s);
		return s < 0;
	endfunction

	function automatic logic [`ACCBUF_ADDR_W-1:0] sat_addr(input int n);
		return (n > 63) ? `ACCBUF_ADDR_W'(63) : `ACCBUF_ADDR_W'(n);
	endfunction

	// zero means endless, which never ends with a count
	function automatic int expected_shots(input logic [`SHOT_W-1:0] n);
		return int'(n);
	endfunction

	task automatic value_fail(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	task automatic problem(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	always @(posedge dspif) begin
		cyc++;
		if (!rst_n) begin
			if (in_run && run_n == '0 && starts < 8) begin
				problem("endless run stopped before 8 shots");
			end else if (in_run && run_n != '0) begin
				problem("shot run cut short by reset");
			end
			in_run = 1'b0;
			armed  = 1'b1;
			exp_bb = '0;
			gate_prev = 2'b00;
			for (int c = 0; c < 2; c++) begin
				ref_sum[c] = '0;
				writes[c]  = 0;
				val_q[c].delete();
				due_q[c].delete();
				sign_q[c].delete();
				sign_due[c].delete();
			end
		end else if (armed) begin
			// outputs straight after reset
			if (!rst_prev && (proc_reset !== 1'b1 || proc_start !== 1'b0 ||
				last_shot_done !== 1'b0 || procdone_flag !== 1'b0 || shot_cnt !== '0 ||
				accbuf[0].we !== 1'b0 || accbuf[1].we !== 1'b0 || accbuf[0].addr !== '0 ||
				accbuf[1].addr !== '0 || meas.valid !== 2'b00)) begin
				value_fail("outputs differ from their reset values");
			end
			// shot sequencing
			if (stb_start) begin
				run_n     = nshot;
				starts    = 0;
				start_due = cyc + 1;
				in_run    = 1'b1;
			end
			if (proc_start) begin
				if (!in_run) begin
					problem("proc_start seen outside a run");
				end
				if (ps_prev) begin
					problem("proc_start lasted longer than one cycle");
				end
				if (proc_reset) begin
					value_fail("proc_reset high during start");
				end
				if (starts == 0 && cyc != start_due) begin
					value_fail($sformatf("first proc_start at cycle %0d, expected %0d",
						cyc, start_due));
				end
				if (starts > 0 && shot_cnt !== `SHOT_W'(starts - 1)) begin
					value_fail($sformatf("shot_cnt %0d, expected %0d", shot_cnt, starts - 1));
				end
				if (starts > 0 && !procdone_flag) begin
					value_fail("procdone_flag low before next shot");
				end
				starts++;
				clear_due = cyc + 1;
			end
			if (cyc == clear_due && procdone_flag) begin
				value_fail("procdone_flag not cleared by proc_start");
			end
			if (last_shot_done) begin
				if (starts != expected_shots(run_n)) begin
					value_fail($sformatf("%0d shots for nshot %0d", starts, run_n));
				end
				if (!procdone_flag) begin
					value_fail("procdone_flag low at run end");
				end
				in_run = 1'b0;
			end
			// cores stay in reset between runs
			if (!in_run && !proc_reset) begin
				value_fail("proc_reset low outside a run");
			end
			for (int c = 0; c < 2; c++) begin
				// source selection, two cycles of latency
				if (bb[c] !== exp_bb[c]) begin
					value_fail($sformatf("bb%0d %h, expected %h", c + 1, bb[c], exp_bb[c]));
				end
				// integration over the gate
				if (acc_gate[c]) begin
					ref_sum[c] = ref_sum[c] + lane_total(exp_bb[c]);
				end else if (gate_prev[c]) begin
					val_q[c].push_back(scaled(ref_sum[c], shift));
					due_q[c].push_back(cyc + 2);
					ref_sum[c] = '0;
				end
				gate_prev[c] = acc_gate[c];
				exp_bb[c] = pick_source(sel[c], adc_d, dac_d[2*c], dac_d[2*c+1], exp_bb[c]);
				// buffer writes
				if (accbuf[c].we) begin
					if (val_q[c].size() == 0) begin
						problem("buffer write with no pending result");
					end else begin
						v = val_q[c].pop_front();
						d = due_q[c].pop_front();
						if (cyc != d) begin
							value_fail($sformatf("ch%0d write at cycle %0d, due %0d", c, cyc, d));
						end
						if (accbuf[c].data !== v) begin
							value_fail($sformatf("ch%0d data %0d, expected %0d", c,
								$signed(accbuf[c].data), v));
						end
						if (accbuf[c].addr !== sat_addr(writes[c])) begin
							value_fail($sformatf("ch%0d addr %0d, expected %0d", c,
								accbuf[c].addr, sat_addr(writes[c])));
						end
						sign_q[c].push_back(sign_of(v));
						sign_due[c].push_back(cyc + 1);
						writes[c]++;
					end
				end else if (due_q[c].size() > 0 && due_q[c][0] < cyc) begin
					problem("accumulator result produced no buffer write");
					void'(val_q[c].pop_front());
					void'(due_q[c].pop_front());
				end
				// measurement bits
				if (meas.valid[c]) begin
					if (sign_q[c].size() == 0 || sign_due[c][0] != cyc) begin
						problem("measurement bit with no matching write");
					end else if (meas.bits[c] !== sign_q[c][0]) begin
						value_fail($sformatf("ch%0d meas bit %b, expected %b", c,
							meas.bits[c], sign_q[c][0]));
					end
					if (sign_q[c].size() > 0) begin
						void'(sign_q[c].pop_front());
						void'(sign_due[c].pop_front());
					end
				end else if (sign_due[c].size() > 0 && sign_due[c][0] < cyc) begin
					problem("buffer write produced no measurement bit");
					void'(sign_q[c].pop_front());
					void'(sign_due[c].pop_front());
				end
				if (resetacc) begin
					if (writes[c] < 70) begin
						problem("fewer than 70 buffer writes before resetacc");
					end
					writes[c] = 0;
				end
				if (final_check && (val_q[c].size() > 0 || sign_q[c].size() > 0)) begin
					problem("results still pending at the end of the run");
				end
			end
		end
		ps_prev  = proc_start;
		rst_prev = rst_n;
		adc_d    = adc;
		dac_d    = dac;
	end

endmodule

//--- testbench/tb_top.sv
// Readout DSP testbench
`include "dsp_config.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	// worst case per shot and per sample phase, doubled for the limit
	localparam int SEQ_CYCLES    = 18 * 40;
	localparam int SAMPLE_CYCLES = 400 + 200 + 60;
	localparam int CYCLE_LIMIT   = 2 * (SEQ_CYCLES + SAMPLE_CYCLES);

	logic                                     dspif = 1'b0;
	logic                                     rst_n;
	logic                                     stb_start;
	logic [`SHOT_W-1:0]                       nshot;
	logic [3:0]                               proc_done;
	logic [3:0]                               no_busy;
	logic                                     proc_reset;
	logic                                     proc_start;
	logic [`SHOT_W-1:0]                       shot_cnt;
	logic                                     last_shot_done;
	logic                                     procdone_flag;
	logic [`ADC_LANES*`LANE_W-1:0]            adc;
	logic [`N_DAC-1:0][`DAC_LANES*`LANE_W-1:0] dac;
	dsp_pkg::bb_sel_e                         bb1_sel;
	dsp_pkg::bb_sel_e                         bb2_sel;
	logic [`ADC_LANES*`LANE_W-1:0]            bb1;
	logic [`ADC_LANES*`LANE_W-1:0]            bb2;
	logic [1:0]                               acc_gate;
	logic [`SHIFT_W-1:0]                      shift;
	logic                                     resetacc;
	dsp_pkg::accbuf_wr_t [1:0]                accbuf;
	dsp_pkg::meas_bits_t                      meas;
	logic                                     final_check;
	logic                                     cores_on;
	int                                       errors;
	int                                       cycles = 0;
	// core model state
	int                                       run_phase;
	int                                       done_wait;
	int                                       idle_wait;

	always #50 dspif = ~dspif;

	dsp_readout_top dut (
		.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
		.proc_done(proc_done), .no_busy(no_busy), .proc_reset(proc_reset),
		.proc_start(proc_start), .shot_cnt(shot_cnt), .last_shot_done(last_shot_done),
		.procdone_flag(procdone_flag), .adc(adc), .dac(dac), .bb1_sel(bb1_sel),
		.bb2_sel(bb2_sel), .bb1(bb1), .bb2(bb2), .acc_gate(acc_gate), .shift(shift),
		.resetacc(resetacc), .accbuf(accbuf), .meas(meas)
	);

	tb_checker u_checker (
		.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
		.proc_reset(proc_reset), .proc_start(proc_start), .shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done), .procdone_flag(procdone_flag), .adc(adc),
		.dac(dac), .sel({bb2_sel, bb1_sel}), .bb({bb2, bb1}), .acc_gate(acc_gate),
		.shift(shift), .resetacc(resetacc), .accbuf(accbuf), .meas(meas),
		.final_check(final_check), .errors(errors)
	);

	// run limit
	always @(posedge dspif) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// four cores answering together after random delays
	always @(negedge dspif) begin
		if (!rst_n) begin
			proc_done = 4'h0;
			no_busy   = 4'hf;
			run_phase = 0;
		end else if (proc_start && cores_on) begin
			proc_done = 4'h0;
			no_busy   = 4'h0;
			done_wait = int'($urandom_range(8, 1));
			run_phase = 1;
		end else if (run_phase == 1) begin
			if (done_wait == 0) begin
				proc_done = 4'hf;
				idle_wait = int'($urandom_range(5, 0));
				run_phase = 2;
			end else begin
				done_wait--;
			end
		end else if (run_phase == 2 && proc_reset) begin
			// done drops once the cores are held in reset
			proc_done = 4'h0;
			if (idle_wait == 0) begin
				no_busy   = 4'hf;
				run_phase = 0;
			end else begin
				idle_wait--;
			end
		end
	end

	task automatic run_shots(input logic [`SHOT_W-1:0] n);
		int starts;
		starts = 0;
		@(negedge dspif);
		nshot = n;
		@(negedge dspif);
		stb_start = 1'b1;
		@(negedge dspif);
		stb_start = 1'b0;
		if (n != '0) begin
			while (!last_shot_done) begin
				@(negedge dspif);
			end
			repeat (3) @(negedge dspif);
		end else begin
			// endless run, stall the cores then reset
			while (starts < 9) begin
				if (proc_start) begin
					starts++;
				end
				@(negedge dspif);
			end
			cores_on = 1'b0;
			repeat (4) @(negedge dspif);
			rst_n = 1'b0;
			repeat (2) @(negedge dspif);
			rst_n    = 1'b1;
			cores_on = 1'b1;
			repeat (2) @(negedge dspif);
		end
	endtask

	task automatic drive_samples(input int n);
		repeat (n) begin
			@(negedge dspif);
			adc = {$urandom, $urandom};
			for (int w = 0; w < `N_DAC; w++) begin
				for (int j = 0; j < 8; j++) begin
					dac[w][j*32 +: 32] = $urandom;
				end
			end
			bb1_sel     = dsp_pkg::bb_sel_e'($urandom_range(3, 0));
			bb2_sel     = dsp_pkg::bb_sel_e'($urandom_range(3, 0));
			// gate high about two thirds of the time
			acc_gate[0] = ($urandom_range(2, 0) != 0);
			acc_gate[1] = ($urandom_range(2, 0) != 0);
			shift       = `SHIFT_W'($urandom_range(8, 0));
		end
	endtask

	task automatic hold_quiet(input int n);
		@(negedge dspif);
		acc_gate = 2'b00;
		repeat (n) @(negedge dspif);
	endtask

	initial begin
		void'($urandom(32'he0dd0ab1));
		rst_n       = 1'b0;
		stb_start   = 1'b0;
		nshot       = '0;
		proc_done   = 4'h0;
		no_busy     = 4'hf;
		adc         = '0;
		dac         = '0;
		bb1_sel     = dsp_pkg::bb_adc;
		bb2_sel     = dsp_pkg::bb_adc;
		acc_gate    = 2'b00;
		shift       = '0;
		resetacc    = 1'b0;
		final_check = 1'b0;
		cores_on    = 1'b1;
		repeat (2) @(negedge dspif);
		rst_n = 1'b1;
		run_shots(`SHOT_W'(1));
		run_shots(`SHOT_W'(3));
		run_shots(`SHOT_W'(5));
		run_shots(`SHOT_W'(0));
		drive_samples(400);
		hold_quiet(6);
		resetacc = 1'b1;
		@(negedge dspif);
		resetacc = 1'b0;
		hold_quiet(3);
		drive_samples(200);
		hold_quiet(6);
		final_check = 1'b1;
		@(negedge dspif);
		final_check = 1'b0;
		@(negedge dspif);
		$display("checks done after %0d cycles, %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+verilog
verilog/dsp_pkg.sv
verilog/shot_sequencer.sv
verilog/baseband_select.sv
verilog/meas_accumulator.sv
verilog/accbuf_writer.sv
verilog/dsp_readout_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the readout DSP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_top \
	--Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1
